// File: Makefile
TOP = eth_rx_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f $(wildcard logic/*.sv test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: files.f
logic/eth_frame_pkg.sv
logic/eth_host_pkg.sv
logic/eth_crc32.sv
logic/eth_rx_frame.sv
logic/eth_rx_buffer.sv
logic/eth_rx_host_wb.sv
logic/eth_rx_top.sv
test/eth_rx_clock_gen.sv
test/eth_rx_tb.sv

// File: logic/eth_crc32.sv
`timescale 1ns/1ns
`default_nettype none

module eth_crc32 (
   input  logic                 RX_CLK,
   input  logic                 rx_rst,
   input  logic                 start,
   input  eth_frame_pkg::byte_t data,
   input  logic                 en,
   output eth_frame_pkg::crc_t  crc,
   output logic                 match
);
   import eth_frame_pkg::*;

   // one byte, lsb first as it came off the wire
   function automatic crc_t crc_step(crc_t c, byte_t d);
      crc_t r;
      r = c;
      for (int i = 0; i < 8; i++) begin
         if (r[31] ^ d[i])
            r = {r[30:0], 1'b0} ^ crc_poly;
         else
            r = {r[30:0], 1'b0};
      end
      return r;
   endfunction

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst)
         crc <= '1;
      else if (start)
         crc <= '1;
      else if (en)
         crc <= crc_step(crc, data);
   end

   // good fcs leaves the fixed residue
   assign match = (crc == crc_residue);

   // receiver never restarts on a byte it is still feeding
   assert property (@(posedge RX_CLK) disable iff (rx_rst) !(start && en));

endmodule

`default_nettype wire

// File: logic/eth_frame_pkg.sv
`default_nettype none

package eth_frame_pkg;

   typedef logic [47:0] mac_addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [31:0] crc_t;
   typedef logic [10:0] frame_len_t;

   // own address, locally administered
   localparam mac_addr_t station_mac   = 48'h02_00_5e_10_20_30;
   localparam mac_addr_t broadcast_mac = 48'hffff_ffff_ffff;

   localparam byte_t sfd_byte = 8'hd5;

   // crc register kept msb first, bits enter in wire order
   localparam crc_t crc_poly    = 32'h04c1_1db7;
   localparam crc_t crc_residue = 32'hc704_dd7b;

   localparam int mac_bytes       = 6;
   localparam int fcs_bytes       = 4;
   localparam int min_frame_bytes = 18;
   localparam int max_frame_bytes = 2048;

   // verdict handed to the host port with frame_done
   typedef struct packed {
      logic       crc_ok;
      frame_len_t length;
   } rx_status_t;

endpackage

`default_nettype wire

// File: logic/eth_host_pkg.sv
`default_nettype none

package eth_host_pkg;

   typedef logic [8:0]  buf_addr_t;
   typedef logic [31:0] wb_word_t;
   typedef logic [11:0] wb_adr_t;

   localparam int buf_words = 512;

   // register map, byte addresses
   localparam wb_adr_t reg_status = 12'h000;
   localparam wb_adr_t reg_drops  = 12'h004;
   localparam wb_adr_t buf_base   = 12'h800;

   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_adr_t  adr;
      wb_word_t dat;
   } wb_req_t;

   typedef struct packed {
      wb_word_t dat;
      logic     ack;
   } wb_rsp_t;

   typedef struct packed {
      logic      en;
      buf_addr_t addr;
      wb_word_t  data;
   } buf_wr_t;

endpackage

`default_nettype wire

// File: logic/eth_rx_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_buffer (
   input  logic                    RX_CLK,
   input  eth_host_pkg::buf_wr_t   wr,
   input  eth_host_pkg::buf_addr_t rd_addr,
   output eth_host_pkg::wb_word_t  rd_data
);
   import eth_host_pkg::*;

   wb_word_t mem [buf_words];

   // receiver side
   always_ff @(posedge RX_CLK) begin
      if (wr.en)
         mem[wr.addr] <= wr.data;
   end

   // host side, one cycle read latency
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: logic/eth_rx_frame.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_frame (
   input  logic                      RX_CLK,
   input  logic                      rx_rst,
   input  logic                      mii_dv,
   input  logic [3:0]                mii_data,
   input  logic                      buf_busy,
   input  logic                      crc_match,
   output logic                      crc_start,
   output eth_frame_pkg::byte_t      crc_byte,
   output logic                      crc_en,
   output eth_host_pkg::buf_wr_t     buf_wr,
   output logic                      frame_done,
   output logic                      frame_drop,
   output eth_frame_pkg::rx_status_t status
);
   import eth_frame_pkg::*;
   import eth_host_pkg::*;

   typedef enum logic [2:0] {
      idle, hunt_sfd, dest_addr, payload, discard, finish
   } rx_state_t;

   rx_state_t   state;
   logic        dv_q;
   logic [3:0]  nib_q;
   logic [3:0]  low_nib;
   logic        phase;
   byte_t       cur_byte;
   logic        byte_vld;
   logic [11:0] cnt;
   mac_addr_t   dest;
   mac_addr_t   dest_next;
   logic        addr_hit;
   logic        busy_q;
   logic        store;
   wb_word_t    wdat;

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst)
         dv_q <= 1'b0;
      else
         dv_q <= mii_dv;
   end

   always_ff @(posedge RX_CLK) begin
      nib_q   <= mii_data;
      low_nib <= nib_q;
   end

   // low nibble arrives first
   assign cur_byte  = {nib_q, low_nib};
   assign byte_vld  = dv_q && phase;
   assign dest_next = {dest[39:0], cur_byte};
   assign addr_hit  = (dest_next == station_mac) || (dest_next == broadcast_mac);
   assign store     = (state == payload) || (state == dest_addr && !busy_q);

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state      <= idle;
         phase      <= 1'b0;
         cnt        <= '0;
         busy_q     <= 1'b0;
         crc_start  <= 1'b0;
         crc_en     <= 1'b0;
         frame_drop <= 1'b0;
         buf_wr     <= '0;
      end else begin
         crc_start  <= 1'b0;
         crc_en     <= 1'b0;
         frame_drop <= 1'b0;
         buf_wr.en  <= 1'b0;
         if (dv_q)
            phase <= !phase;
         case (state)
            idle: if (dv_q) state <= hunt_sfd;
            hunt_sfd: begin
               if (!dv_q) begin
                  state <= idle;
               end else if (cur_byte == sfd_byte) begin
                  // byte alignment comes from the delimiter
                  state     <= dest_addr;
                  phase     <= 1'b0;
                  cnt       <= '0;
                  busy_q    <= buf_busy;
                  crc_start <= 1'b1;
               end
            end
            dest_addr, payload: begin
               if (!dv_q) begin
                  if (state == payload && cnt >= min_frame_bytes) begin
                     state <= finish;
                     if (cnt[1:0] != 2'd0) begin
                        buf_wr.en   <= 1'b1;
                        buf_wr.addr <= cnt[10:2];
                        buf_wr.data <= wdat;
                     end
                  end else begin
                     state <= idle;
                  end
               end else if (byte_vld) begin
                  cnt    <= cnt + 12'd1;
                  crc_en <= 1'b1;
                  if (state == dest_addr && cnt == mac_bytes - 1) begin
                     if (!addr_hit) begin
                        state <= discard;
                     end else if (busy_q) begin
                        state      <= discard;
                        frame_drop <= 1'b1;
                     end else begin
                        state <= payload;
                     end
                  end
                  // oversize, buffer already full
                  if (state == payload && cnt == max_frame_bytes)
                     state <= discard;
                  if (store && cnt[1:0] == 2'd3) begin
                     buf_wr.en   <= 1'b1;
                     buf_wr.addr <= cnt[10:2];
                     buf_wr.data <= {cur_byte, wdat[23:0]};
                  end
               end
            end
            discard: if (!dv_q) state <= idle;
            finish: state <= idle;
            default: state <= idle;
         endcase
      end
   end

   // little endian word packing and address shift
   always_ff @(posedge RX_CLK) begin
      if (byte_vld)
         crc_byte <= cur_byte;
      if (state == dest_addr && byte_vld)
         dest <= dest_next;
      if (state == hunt_sfd || (byte_vld && cnt[1:0] == 2'd3))
         wdat <= '0;
      else if (byte_vld && (state == dest_addr || state == payload))
         wdat[8*cnt[1:0] +: 8] <= cur_byte;
   end

   // a leftover nibble means the frame was cut mid byte
   assign frame_done    = (state == finish);
   assign status.crc_ok = crc_match && !phase;
   assign status.length = frame_len_t'(cnt - fcs_bytes);

   assert property (@(posedge RX_CLK) disable iff (rx_rst)
      (state == discard) |-> !buf_wr.en);

   assert property (@(posedge RX_CLK) disable iff (rx_rst)
      !(frame_done && frame_drop));

endmodule

`default_nettype wire

// File: logic/eth_rx_host_wb.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_host_wb (
   input  logic                      RX_CLK,
   input  logic                      rx_rst,
   input  eth_host_pkg::wb_req_t     wb_req,
   output eth_host_pkg::wb_rsp_t     wb_rsp,
   input  logic                      frame_done,
   input  logic                      frame_drop,
   input  eth_frame_pkg::rx_status_t status,
   output eth_host_pkg::buf_addr_t   rd_addr,
   input  eth_host_pkg::wb_word_t    rd_data,
   output logic                      buf_busy,
   output logic                      ready
);
   import eth_frame_pkg::*;
   import eth_host_pkg::*;

   typedef enum logic {ack_idle, ack_data} ack_state_t;

   ack_state_t  ack_state;
   rx_status_t  status_q;
   logic        ready_q;
   logic [15:0] drops;
   logic        req;
   logic        release_wr;

   assign req        = wb_req.cyc && wb_req.stb;
   assign release_wr = (ack_state == ack_data) && req && wb_req.we &&
                       (wb_req.adr == reg_status);
   assign rd_addr    = wb_req.adr[10:2];
   assign buf_busy   = ready_q;
   assign ready      = ready_q;

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         ready_q  <= 1'b0;
         status_q <= '0;
      end else if (frame_done) begin
         ready_q  <= 1'b1;
         status_q <= status;
      end else if (release_wr) begin
         ready_q <= 1'b0;
      end
   end

   // saturating drop count
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst)
         drops <= '0;
      else if (frame_drop && drops != 16'hffff)
         drops <= drops + 16'd1;
   end

   // second state waits out the registered ram read
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         ack_state <= ack_idle;
         wb_rsp    <= '0;
      end else begin
         wb_rsp.ack <= 1'b0;
         case (ack_state)
            ack_idle: if (req && !wb_rsp.ack) ack_state <= ack_data;
            ack_data: begin
               ack_state  <= ack_idle;
               wb_rsp.ack <= 1'b1;
               if (wb_req.adr >= buf_base)
                  wb_rsp.dat <= rd_data;
               else if (wb_req.adr == reg_status)
                  wb_rsp.dat <= {5'd0, status_q.length, 14'd0, status_q.crc_ok, ready_q};
               else if (wb_req.adr == reg_drops)
                  wb_rsp.dat <= {16'd0, drops};
               else
                  wb_rsp.dat <= '0;
            end
            default: ack_state <= ack_idle;
         endcase
      end
   end

   assert property (@(posedge RX_CLK) disable iff (rx_rst)
      wb_rsp.ack |=> !wb_rsp.ack);

endmodule

`default_nettype wire

// File: logic/eth_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_top (
   input  logic                  RX_CLK,
   input  logic                  rx_rst,
   input  logic                  mii_dv,
   input  logic [3:0]            mii_data,
   input  eth_host_pkg::wb_req_t wb_req,
   output eth_host_pkg::wb_rsp_t wb_rsp,
   output logic                  ready
);
   import eth_frame_pkg::*;
   import eth_host_pkg::*;

   logic       crc_start;
   logic       crc_en;
   logic       crc_match;
   byte_t      crc_byte;
   buf_wr_t    buf_wr;
   logic       frame_done;
   logic       frame_drop;
   logic       buf_busy;
   rx_status_t status;
   buf_addr_t  rd_addr;
   wb_word_t   rd_data;

   eth_rx_frame frame_i (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .mii_dv     (mii_dv),
      .mii_data   (mii_data),
      .buf_busy   (buf_busy),
      .crc_match  (crc_match),
      .crc_start  (crc_start),
      .crc_byte   (crc_byte),
      .crc_en     (crc_en),
      .buf_wr     (buf_wr),
      .frame_done (frame_done),
      .frame_drop (frame_drop),
      .status     (status)
   );

   // raw crc value is only for debug
   eth_crc32 crc_i (
      .RX_CLK (RX_CLK),
      .rx_rst (rx_rst),
      .start  (crc_start),
      .data   (crc_byte),
      .en     (crc_en),
      .crc    (),
      .match  (crc_match)
   );

   eth_rx_buffer buffer_i (
      .RX_CLK  (RX_CLK),
      .wr      (buf_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   eth_rx_host_wb host_i (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .wb_req     (wb_req),
      .wb_rsp     (wb_rsp),
      .frame_done (frame_done),
      .frame_drop (frame_drop),
      .status     (status),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .buf_busy   (buf_busy),
      .ready      (ready)
   );

endmodule

`default_nettype wire

// File: test/eth_rx_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_clock_gen (
   output logic RX_CLK,
   output logic rx_rst
);

   initial begin
      RX_CLK = 1'b0;
      forever #5 RX_CLK = ~RX_CLK;
   end

   // reset held over the first five rising edges
   initial begin
      rx_rst = 1'b1;
      repeat (5) @(posedge RX_CLK);
      rx_rst <= 1'b0;
   end

endmodule

`default_nettype wire

// File: test/eth_rx_tb.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_tb;
   import eth_frame_pkg::*;
   import eth_host_pkg::*;

   logic       RX_CLK;
   logic       rx_rst;
   logic       mii_dv;
   logic [3:0] mii_data;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;
   logic       ready;

   // bytes after the delimiter, fcs included
   byte_t  frame_q[$];
   integer seed;
   int     n_checks;
   int     n_errors;

   eth_rx_clock_gen clock_i (.RX_CLK(RX_CLK), .rx_rst(rx_rst));

   eth_rx_top dut_i (
      .RX_CLK   (RX_CLK),
      .rx_rst   (rx_rst),
      .mii_dv   (mii_dv),
      .mii_data (mii_data),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .ready    (ready)
   );

   // reflected crc-32 as sent on the wire
   function automatic crc_t crc32_ref(int n);
      crc_t c;
      c = 32'hffff_ffff;
      for (int i = 0; i < n; i++) begin
         c = c ^ crc_t'(frame_q[i]);
         for (int b = 0; b < 8; b++)
            c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
      end
      return ~c;
   endfunction

   // little endian, missing bytes read as zero
   function automatic wb_word_t pack_word(int idx);
      wb_word_t w;
      w = '0;
      for (int k = 0; k < 4; k++)
         if (4 * idx + k < frame_q.size())
            w[8 * k +: 8] = frame_q[4 * idx + k];
      return w;
   endfunction

   task automatic check_word(input string name, input wb_word_t exp, input wb_word_t got);
      n_checks++;
      if (got !== exp) begin
         $display("error %s: expected %h, got %h", name, exp, got);
         n_errors++;
      end
   endtask

   task automatic check_status(input string name, input rx_status_t exp, input rx_status_t got);
      n_checks++;
      if (got !== exp) begin
         $display("error %s: expected crc_ok %0d length %0d, got crc_ok %0d length %0d",
                  name, exp.crc_ok, exp.length, got.crc_ok, got.length);
         n_errors++;
      end
   endtask

   task automatic check_count(input string name, input logic [15:0] exp, input logic [15:0] got);
      n_checks++;
      if (got !== exp) begin
         $display("error %s: expected %0d, got %0d", name, exp, got);
         n_errors++;
      end
   endtask

   task automatic make_frame(input mac_addr_t dst, input int n_payload);
      crc_t fcs;
      frame_q.delete();
      for (int i = 5; i >= 0; i--)
         frame_q.push_back(dst[8 * i +: 8]);
      for (int i = 0; i < 6; i++)
         frame_q.push_back(byte_t'(8'h40 + i));
      frame_q.push_back(8'h08);
      frame_q.push_back(8'h00);
      for (int i = 0; i < n_payload; i++)
         frame_q.push_back(byte_t'($random(seed)));
      fcs = crc32_ref(frame_q.size());
      for (int i = 0; i < 4; i++)
         frame_q.push_back(fcs[8 * i +: 8]);
   endtask

   task automatic send_nibble(input logic [3:0] n);
      @(posedge RX_CLK);
      mii_dv   <= 1'b1;
      mii_data <= n;
   endtask

   task automatic send_byte(input byte_t b);
      send_nibble(b[3:0]);
      send_nibble(b[7:4]);
   endtask

   task automatic send_frame(input bit odd_nibble);
      // inter frame gap
      repeat (12) @(posedge RX_CLK);
      repeat (7) send_byte(8'h55);
      send_byte(sfd_byte);
      foreach (frame_q[i])
         send_byte(frame_q[i]);
      if (odd_nibble)
         send_nibble(4'h0);
      @(posedge RX_CLK);
      mii_dv   <= 1'b0;
      mii_data <= 4'h0;
   endtask

   task automatic wb_xfer(input logic we, input wb_adr_t adr, input wb_word_t wdat,
                          output wb_word_t rdat);
      wb_req_t r;
      int      t;
      r     = '0;
      r.cyc = 1'b1;
      r.stb = 1'b1;
      r.we  = we;
      r.adr = adr;
      r.dat = wdat;
      @(posedge RX_CLK);
      wb_req <= r;
      t = 0;
      do begin
         @(negedge RX_CLK);
         t++;
      end while (!wb_rsp.ack && t < 20);
      if (!wb_rsp.ack) begin
         $display("timeout: no wishbone ack for address %h", adr);
         n_errors++;
      end
      rdat = wb_rsp.dat;
      @(posedge RX_CLK);
      wb_req <= '0;
   endtask

   task automatic wb_read(input wb_adr_t adr, output wb_word_t rdat);
      wb_xfer(1'b0, adr, '0, rdat);
   endtask

   task automatic wb_write(input wb_adr_t adr, input wb_word_t wdat);
      wb_word_t unused;
      wb_xfer(1'b1, adr, wdat, unused);
   endtask

   task automatic wait_ready(input string name);
      int t;
      t = 0;
      do begin
         @(negedge RX_CLK);
         t++;
      end while (!ready && t < 7);
      if (!ready) begin
         $display("timeout: ready did not rise after %s", name);
         n_errors++;
      end
   endtask

   // status, ready bit and every stored word
   task automatic check_frame(input string name, input bit exp_crc_ok);
      wb_word_t   w;
      rx_status_t exp_s;
      rx_status_t got_s;
      wb_read(reg_status, w);
      check_word({name, " ready bit"}, 32'd1, {31'd0, w[0]});
      exp_s.crc_ok = exp_crc_ok;
      exp_s.length = frame_len_t'(frame_q.size() - 4);
      got_s.crc_ok = w[1];
      got_s.length = w[26:16];
      check_status(name, exp_s, got_s);
      for (int i = 0; i < (frame_q.size() + 3) / 4; i++) begin
         wb_read(buf_base + wb_adr_t'(4 * i), w);
         check_word($sformatf("%s word %0d", name, i), pack_word(i), w);
      end
   endtask

   task automatic release_buffer(input string name);
      wb_word_t w;
      wb_write(reg_status, 32'd0);
      @(negedge RX_CLK);
      check_word({name, " ready output"}, 32'd0, {31'd0, ready});
      wb_read(reg_status, w);
      check_word({name, " ready bit"}, 32'd0, {31'd0, w[0]});
   endtask

   task automatic check_drops(input string name, input logic [15:0] exp);
      wb_word_t w;
      wb_read(reg_drops, w);
      check_count(name, exp, w[15:0]);
   endtask

   initial begin
      wb_word_t w;
      byte_t    saved_q[$];
      int       t;
      int       hits;
      seed     = 93;
      n_checks = 0;
      n_errors = 0;
      mii_dv   = 1'b0;
      mii_data = 4'h0;
      wb_req   = '0;
      t = 0;
      do begin
         @(negedge RX_CLK);
         t++;
      end while (rx_rst && t < 20);
      if (rx_rst) begin
         $display("timeout: reset was never released");
         n_errors++;
      end

      wb_read(reg_status, w);
      check_word("reset status", 32'd0, w);
      check_drops("reset drops", 16'd0);
      @(negedge RX_CLK);
      check_word("reset ready output", 32'd0, {31'd0, ready});

      make_frame(station_mac, 46);
      send_frame(1'b0);
      wait_ready("station frame");
      check_frame("station frame", 1'b1);
      release_buffer("station frame");

      make_frame(broadcast_mac, 47);
      send_frame(1'b0);
      wait_ready("broadcast frame");
      check_frame("broadcast frame", 1'b1);
      release_buffer("broadcast frame");

      // one bit off the station address
      make_frame(48'h02_00_5e_10_20_31, 50);
      send_frame(1'b0);
      hits = 0;
      repeat (200) begin
         @(negedge RX_CLK);
         if (ready)
            hits++;
      end
      check_word("other address ready cycles", 32'd0, 32'(hits));
      check_drops("other address drops", 16'd0);

      make_frame(station_mac, 60);
      frame_q[20] = frame_q[20] ^ 8'h40;
      send_frame(1'b0);
      wait_ready("corrupt frame");
      check_frame("corrupt frame", 1'b0);
      release_buffer("corrupt frame");

      make_frame(station_mac, 45);
      send_frame(1'b1);
      wait_ready("odd nibble frame");
      check_frame("odd nibble frame", 1'b0);
      release_buffer("odd nibble frame");

      // second frame arrives while the buffer is held
      make_frame(station_mac, 49);
      send_frame(1'b0);
      wait_ready("held frame");
      saved_q = frame_q;
      make_frame(broadcast_mac, 52);
      send_frame(1'b0);
      check_drops("backpressure drops", 16'd1);
      frame_q = saved_q;
      check_frame("backpressure held frame", 1'b1);

      release_buffer("release");
      make_frame(station_mac, 64);
      send_frame(1'b0);
      wait_ready("frame after release");
      check_frame("frame after release", 1'b1);
      check_drops("drops after release", 16'd1);

      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire
